// ==== hw/burst_writer.sv ====
// Line burst writer
`timescale 1ns/1ps

module burst_writer #(
	parameter int unsigned PIXELS_PER_LINE = video_ram_pkg::DEF_PIXELS_PER_LINE,
	parameter int unsigned BURST_LEN       = video_ram_pkg::DEF_BURST_LEN,
	parameter int unsigned BYTES_PER_LINE  = video_ram_pkg::DEF_BYTES_PER_LINE,
	parameter logic [31:0] BASE_ADDR       = video_ram_pkg::DEF_BASE_ADDR,
	parameter int unsigned MAX_CREDITS     = video_ram_pkg::DEF_MAX_CREDITS
) (
	input  logic                               i_clk_100_bus,
	input  logic                               i_rst,
	input  logic                               i_mem_ready,
	input  logic                               i_line_ready,
	input  video_ram_pkg::line_num_t           i_line_num,
	input  logic                               i_credit_return,
	input  video_ram_pkg::pixel_t              i_rd_pix,
	output logic                               o_line_take,
	output logic [$clog2(PIXELS_PER_LINE)-1:0] o_rd_addr,
	output video_ram_pkg::mem_beat_t           o_beat,
	output video_ram_pkg::luma_out_t           o_luma
);
	import video_ram_pkg::*;

	localparam int unsigned ADDR_W          = $clog2(PIXELS_PER_LINE);
	// BURST_LEN is a power of two dividing the line
	localparam int unsigned BEAT_W          = $clog2(BURST_LEN);
	localparam int unsigned BURSTS_PER_LINE = PIXELS_PER_LINE / BURST_LEN;
	localparam int unsigned BURST_CNT_W     = $clog2(BURSTS_PER_LINE + 1);
	localparam int unsigned CREDIT_W        = $clog2(MAX_CREDITS + 1);
	localparam logic [31:0] BYTES_PER_BURST = 32'(4 * BURST_LEN);

	wr_state_e              state_q;
	wr_state_e              state_d;
	logic [BURST_CNT_W-1:0] burst_cnt_q;
	logic [CREDIT_W-1:0]    credit_q;
	logic [ADDR_W-1:0]      rd_addr_q;
	logic [31:0]            addr_q;
	logic [31:0]            line_base;
	logic                   credit_take;
	logic                   last_beat;
	// Beat framing, one cycle behind the read address
	logic                   beat_valid_q;
	logic                   beat_first_q;
	logic                   luma_first_q;
	logic [31:0]            beat_addr_q;

	//////////////////////////////////////////////////////////////////////
	// Write sequencing FSM
	//////////////////////////////////////////////////////////////////////

	assign credit_take = (state_q == WR_REQUEST) && (credit_q != '0);
	assign last_beat   = (rd_addr_q[BEAT_W-1:0] == BEAT_W'(BURST_LEN - 1));
	assign o_line_take = (state_q == WR_START_LINE) && i_line_ready;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			// Hold until memory init is done
			WR_INIT:       if (i_mem_ready) state_d = WR_START_LINE;
			// Wait for a full line
			WR_START_LINE: if (i_line_ready) state_d = WR_REQUEST;
			// One credit per burst
			WR_REQUEST:    if (credit_take) state_d = WR_WRITE;
			WR_WRITE:      if (last_beat) state_d = WR_COMPLETE;
			WR_COMPLETE:
			begin
				if (burst_cnt_q == BURST_CNT_W'(BURSTS_PER_LINE))
					state_d = WR_START_LINE;
				else
					state_d = WR_REQUEST;
			end
			default:       state_d = WR_INIT;
		endcase
	end

	// Line base from the latched line number
	assign line_base = BASE_ADDR + 32'(BYTES_PER_LINE) * 32'(i_line_num);

	always_ff @(posedge i_clk_100_bus or posedge i_rst)
	begin
		if (i_rst)
		begin
			state_q      <= WR_INIT;
			burst_cnt_q  <= '0;
			credit_q     <= CREDIT_W'(MAX_CREDITS);
			rd_addr_q    <= '0;
			beat_valid_q <= 1'b0;
			beat_first_q <= 1'b0;
			luma_first_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			// Burst count per line
			if (state_q == WR_START_LINE)
				burst_cnt_q <= '0;
			else if (credit_take)
				burst_cnt_q <= burst_cnt_q + 1'b1;
			// Take and return together cancel out
			if (credit_take && !i_credit_return)
				credit_q <= credit_q - 1'b1;
			else if (!credit_take && i_credit_return)
				credit_q <= credit_q + 1'b1;
			// Pixel read address runs across bursts
			if (state_q == WR_START_LINE)
				rd_addr_q <= '0;
			else if (state_q == WR_WRITE)
				rd_addr_q <= rd_addr_q + 1'b1;
			beat_valid_q <= (state_q == WR_WRITE);
			beat_first_q <= (state_q == WR_WRITE) && (rd_addr_q[BEAT_W-1:0] == '0);
			luma_first_q <= (state_q == WR_WRITE) && (rd_addr_q == '0);
		end
	end

	// Burst address, reloaded at the head of each line
	always_ff @(posedge i_clk_100_bus)
	begin
		if (state_q == WR_REQUEST && burst_cnt_q == '0)
			addr_q <= line_base;
		else if (state_q == WR_COMPLETE)
			addr_q <= addr_q + BYTES_PER_BURST;
		beat_addr_q <= addr_q;
	end

	//////////////////////////////////////////////////////////////////////
	// Output packing
	//////////////////////////////////////////////////////////////////////

	assign o_rd_addr = rd_addr_q;

	always_comb
	begin
		o_beat.valid   = beat_valid_q;
		o_beat.first   = beat_first_q;
		o_beat.addr    = beat_addr_q;
		// Null byte, then RGB with two low bits dropped
		o_beat.data    = {8'h00, i_rd_pix.red[7:2], 2'b00, i_rd_pix.green[7:2], 2'b00,
			i_rd_pix.blue[7:2], 2'b00};
		o_luma.valid    = beat_valid_q;
		o_luma.first    = luma_first_q;
		o_luma.luma     = i_rd_pix.luma;
		o_luma.line_num = i_line_num;
	end

endmodule

// ==== hw/line_capture.sv ====
// Ping-pong line capture
`timescale 1ns/1ps

module line_capture #(
	parameter int unsigned PIXELS_PER_LINE = video_ram_pkg::DEF_PIXELS_PER_LINE
) (
	input  logic                               i_clk_100_bus,
	input  logic                               i_rst,
	input  video_ram_pkg::pix_in_t             i_pix,
	input  logic                               i_line_take,
	output logic                               o_wr_en,
	output logic                               o_wr_bank,
	output logic [$clog2(PIXELS_PER_LINE)-1:0] o_wr_addr,
	output logic                               o_line_ready,
	output logic                               o_rd_bank,
	output video_ram_pkg::line_num_t           o_rd_line_num
);
	import video_ram_pkg::*;

	localparam int unsigned ADDR_W = $clog2(PIXELS_PER_LINE);

	// Write side position
	logic [ADDR_W-1:0] wr_addr_q;
	logic              wr_bank_q;
	// Hand-off to the writer
	logic              line_ready_q;
	logic              rd_bank_q;
	// Line number held by each bank
	line_num_t         bank_line_q [2];
	line_num_t         rd_line_num_q;
	logic              line_done;

	// Closing pixel of the current line
	assign line_done = i_pix.valid && i_pix.eol;

	//////////////////////////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk_100_bus or posedge i_rst)
	begin
		if (i_rst)
		begin
			wr_addr_q <= '0;
			wr_bank_q <= 1'b0;
		end
		else if (line_done)
		begin
			// New line starts at 0 in the other bank
			wr_addr_q <= '0;
			wr_bank_q <= ~wr_bank_q;
		end
		else if (i_pix.valid)
		begin
			wr_addr_q <= wr_addr_q + 1'b1;
		end
	end

	// Tag the finished bank with its line
	always_ff @(posedge i_clk_100_bus)
	begin
		if (line_done)
			bank_line_q[wr_bank_q] <= i_pix.line_num;
	end

	//////////////////////////////////////////////////////////////////////
	// Hand-off to the writer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk_100_bus or posedge i_rst)
	begin
		if (i_rst)
		begin
			line_ready_q <= 1'b0;
			rd_bank_q    <= 1'b0;
		end
		else
		begin
			// A fresh eol wins over a take in the same cycle
			if (line_done)
				line_ready_q <= 1'b1;
			else if (i_line_take)
				line_ready_q <= 1'b0;
			// Most recently finished bank is the one not being written
			if (i_line_take)
				rd_bank_q <= ~wr_bank_q;
		end
	end

	always_ff @(posedge i_clk_100_bus)
	begin
		if (i_line_take)
			rd_line_num_q <= bank_line_q[~wr_bank_q];
	end

	assign o_wr_en       = i_pix.valid;
	assign o_wr_bank     = wr_bank_q;
	assign o_wr_addr     = wr_addr_q;
	assign o_line_ready  = line_ready_q;
	assign o_rd_bank     = rd_bank_q;
	assign o_rd_line_num = rd_line_num_q;

endmodule

// ==== hw/line_store.sv ====
// Two-bank line buffer memory
`timescale 1ns/1ps

module line_store #(
	parameter int unsigned PIXELS_PER_LINE = video_ram_pkg::DEF_PIXELS_PER_LINE
) (
	input  logic                               i_clk_100_bus,
	// Capture side
	input  logic                               i_wr_en,
	input  logic                               i_wr_bank,
	input  logic [$clog2(PIXELS_PER_LINE)-1:0] i_wr_addr,
	input  video_ram_pkg::pixel_t              i_wr_pix,
	// Writer side
	input  logic                               i_rd_bank,
	input  logic [$clog2(PIXELS_PER_LINE)-1:0] i_rd_addr,
	output video_ram_pkg::pixel_t              o_rd_pix
);
	import video_ram_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	// Bank 0 and bank 1, one full line each
	pixel_t mem [2][PIXELS_PER_LINE];
	// Registered read data
	pixel_t rd_pix_q;

	// Capture writes one pixel per valid cycle
	always_ff @(posedge i_clk_100_bus)
	begin
		if (i_wr_en)
			mem[i_wr_bank][i_wr_addr] <= i_wr_pix;
	end

	// Read is always on, data one cycle after address
	always_ff @(posedge i_clk_100_bus)
	begin
		rd_pix_q <= mem[i_rd_bank][i_rd_addr];
	end

	// Banks never collide while the source keeps to one spare line
	assign o_rd_pix = rd_pix_q;

endmodule

// ==== hw/video_ram_pkg.sv ====
// Video to RAM shared types
package video_ram_pkg;

	//////////////////////////////////////////////////////////////////////
	// Default sizing, overridden from the top level
	//////////////////////////////////////////////////////////////////////

	// Pixels held per line bank
	localparam int unsigned DEF_PIXELS_PER_LINE = 64;
	// Words per memory burst
	localparam int unsigned DEF_BURST_LEN       = 16;
	// Line pitch in memory
	localparam int unsigned DEF_BYTES_PER_LINE  = 4096;
	// Frame start in memory
	localparam logic [31:0] DEF_BASE_ADDR       = 32'h0010_0000;
	// Bursts allowed in flight
	localparam int unsigned DEF_MAX_CREDITS     = 2;

	//////////////////////////////////////////////////////////////////////
	// Pixel types
	//////////////////////////////////////////////////////////////////////

	// Line index within the frame
	typedef logic [9:0] line_num_t;

	// One decoded pixel as kept in the line buffer
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
		logic [7:0] luma;
	} pixel_t;

	// Incoming pixel stream, one per valid cycle
	typedef struct packed {
		logic      valid;
		// Last pixel of the line
		logic      eol;
		line_num_t line_num;
		pixel_t    pix;
	} pix_in_t;

	//////////////////////////////////////////////////////////////////////
	// Output channels
	//////////////////////////////////////////////////////////////////////

	// Memory write beat
	typedef struct packed {
		logic        valid;
		// First beat of a burst, addr only meaningful here
		logic        first;
		logic [31:0] addr;
		logic [31:0] data;
	} mem_beat_t;

	// Luma side channel, aligned with the memory beats
	typedef struct packed {
		logic      valid;
		// First luma of the line
		logic      first;
		logic [7:0] luma;
		line_num_t line_num;
	} luma_out_t;

	// Write sequencing FSM
	typedef enum logic [2:0] {
		WR_INIT       = 3'd0,
		WR_START_LINE = 3'd1,
		WR_REQUEST    = 3'd2,
		WR_WRITE      = 3'd3,
		WR_COMPLETE   = 3'd4
	} wr_state_e;

endpackage

// ==== hw/video_to_ram.sv ====
// Video line to RAM top level
`timescale 1ns/1ps

module video_to_ram #(
	parameter int unsigned PIXELS_PER_LINE = video_ram_pkg::DEF_PIXELS_PER_LINE,
	parameter int unsigned BURST_LEN       = video_ram_pkg::DEF_BURST_LEN,
	parameter int unsigned BYTES_PER_LINE  = video_ram_pkg::DEF_BYTES_PER_LINE,
	parameter logic [31:0] BASE_ADDR       = video_ram_pkg::DEF_BASE_ADDR,
	parameter int unsigned MAX_CREDITS     = video_ram_pkg::DEF_MAX_CREDITS
) (
	input  logic                     i_clk_100_bus,
	input  logic                     i_rst,
	input  video_ram_pkg::pix_in_t   i_pix,
	input  logic                     i_mem_ready,
	input  logic                     i_credit_return,
	output video_ram_pkg::mem_beat_t o_beat,
	output video_ram_pkg::luma_out_t o_luma
);
	import video_ram_pkg::*;

	localparam int unsigned ADDR_W = $clog2(PIXELS_PER_LINE);

	// Capture to store
	logic              wr_en;
	logic              wr_bank;
	logic [ADDR_W-1:0] wr_addr;
	// Capture to writer
	logic              line_ready;
	logic              line_take;
	logic              rd_bank;
	line_num_t         rd_line_num;
	// Store to writer
	logic [ADDR_W-1:0] rd_addr;
	pixel_t            rd_pix;

	//////////////////////////////////////////////////////////////////////
	// Instances
	//////////////////////////////////////////////////////////////////////

	line_capture #(
		.PIXELS_PER_LINE (PIXELS_PER_LINE)
	) u_capture (
		.i_clk_100_bus (i_clk_100_bus),
		.i_rst         (i_rst),
		.i_pix         (i_pix),
		.i_line_take   (line_take),
		.o_wr_en       (wr_en),
		.o_wr_bank     (wr_bank),
		.o_wr_addr     (wr_addr),
		.o_line_ready  (line_ready),
		.o_rd_bank     (rd_bank),
		.o_rd_line_num (rd_line_num)
	);

	line_store #(
		.PIXELS_PER_LINE (PIXELS_PER_LINE)
	) u_store (
		.i_clk_100_bus (i_clk_100_bus),
		.i_wr_en       (wr_en),
		.i_wr_bank     (wr_bank),
		.i_wr_addr     (wr_addr),
		.i_wr_pix      (i_pix.pix),
		.i_rd_bank     (rd_bank),
		.i_rd_addr     (rd_addr),
		.o_rd_pix      (rd_pix)
	);

	// Bursts out of the read bank
	burst_writer #(
		.PIXELS_PER_LINE (PIXELS_PER_LINE),
		.BURST_LEN       (BURST_LEN),
		.BYTES_PER_LINE  (BYTES_PER_LINE),
		.BASE_ADDR       (BASE_ADDR),
		.MAX_CREDITS     (MAX_CREDITS)
	) u_writer (
		.i_clk_100_bus   (i_clk_100_bus),
		.i_rst           (i_rst),
		.i_mem_ready     (i_mem_ready),
		.i_line_ready    (line_ready),
		.i_line_num      (rd_line_num),
		.i_credit_return (i_credit_return),
		.i_rd_pix        (rd_pix),
		.o_line_take     (line_take),
		.o_rd_addr       (rd_addr),
		.o_beat          (o_beat),
		.o_luma          (o_luma)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the video_to_ram testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_video_to_ram -f tb.f \
	-Mdir obj_dir -o tb_video_to_ram_sim > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_video_to_ram_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Testbench passed" "$SIM_LOG"; then
	exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1

// ==== tb.f ====
hw/video_ram_pkg.sv
hw/line_capture.sv
hw/line_store.sv
hw/burst_writer.sv
hw/video_to_ram.sv
tests/video_to_ram_sva.sv
tests/tb_video_to_ram.sv

// ==== tests/tb_video_to_ram.sv ====
// Video to RAM testbench
`timescale 1ns/1ps

module tb_video_to_ram;
	import video_ram_pkg::*;

	localparam int PIXELS    = DEF_PIXELS_PER_LINE;
	localparam int BURST     = DEF_BURST_LEN;
	localparam int LINE_STEP = DEF_BYTES_PER_LINE;
	localparam int CREDITS   = DEF_MAX_CREDITS;
	// Worst line takes 64 pixels plus 4 bursts of 16 beats, 2 overhead and 8 credit wait
	// Six such lines and 90 idle cycles need about 1100 cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic      clk_100_bus = 1'b0;
	logic      rst;
	pix_in_t   pix;
	logic      mem_ready;
	logic      credit_return = 1'b0;
	mem_beat_t beat;
	luma_out_t luma;

	// Memory model state
	mem_beat_t beat_q[$];
	luma_out_t luma_q[$];
	int        credit_due[$];
	logic      hold_credits;
	integer    seed;
	int        cycle_cnt = 0;
	int        error_count;
	int        check_count;
	int        tests_passed;
	int        tests_failed;

	video_to_ram uut (
		.i_clk_100_bus   (clk_100_bus),
		.i_rst           (rst),
		.i_pix           (pix),
		.i_mem_ready     (mem_ready),
		.i_credit_return (credit_return),
		.o_beat          (beat),
		.o_luma          (luma)
	);

	// 100 ns period
	always #50 clk_100_bus = ~clk_100_bus;

	always @(posedge clk_100_bus)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: no result after %0d clock cycles", cycle_cnt);
			$display("Testbench failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk_100_bus)
	begin
		if (beat.valid)
			beat_q.push_back(beat);
		if (luma.valid)
			luma_q.push_back(luma);
		// Each burst answered 1 to 8 cycles after its first beat
		if (beat.valid && beat.first)
			credit_due.push_back(cycle_cnt + 1 + int'($unsigned($random(seed)) % 32'd8));
		// One credit pulse per cycle at most
		if (!hold_credits && credit_due.size() != 0 && credit_due[0] <= cycle_cnt)
		begin
			void'(credit_due.pop_front());
			credit_return <= 1'b1;
		end
		else
			credit_return <= 1'b0;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus and expected values
	//////////////////////////////////////////////////////////////////////

	// Pattern differs per line so banks cannot be confused
	function automatic pixel_t pixel_for(input int line, input int idx);
		pixel_t p;
		p.red   = 8'(idx * 4 + 3);
		p.green = 8'(line * 20 + 2);
		p.blue  = 8'(255 - idx * 4 - line * 8);
		p.luma  = 8'(idx + line * 64);
		return p;
	endfunction

	function automatic mem_beat_t expected_beat(input int line, input int idx);
		mem_beat_t b;
		pixel_t    p;
		p       = pixel_for(line, idx);
		b.valid = 1'b1;
		b.first = (idx % BURST == 0);
		b.addr  = DEF_BASE_ADDR + 32'(line * LINE_STEP) + 32'((idx / BURST) * BURST * 4);
		// Top byte zero, colour bytes with two low bits cleared
		b.data  = {8'h00, p.red & 8'hfc, p.green & 8'hfc, p.blue & 8'hfc};
		return b;
	endfunction

	function automatic luma_out_t expected_luma(input int line, input int idx);
		luma_out_t l;
		pixel_t    p;
		p          = pixel_for(line, idx);
		l.valid    = 1'b1;
		l.first    = (idx == 0);
		l.luma     = p.luma;
		l.line_num = line_num_t'(line);
		return l;
	endfunction

	task automatic send_line(input int line);
		pix_in_t p;
		for (int i = 0; i < PIXELS; i++)
		begin
			@(posedge clk_100_bus);
			p.valid    = 1'b1;
			p.eol      = (i == PIXELS - 1);
			p.line_num = line_num_t'(line);
			p.pix      = pixel_for(line, i);
			pix <= p;
		end
		@(posedge clk_100_bus);
		pix <= '0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare and wait helpers
	//////////////////////////////////////////////////////////////////////

	task automatic compare_beat(input mem_beat_t got, input mem_beat_t exp, input string what);
		check_count++;
		// Address is only defined on the first beat
		if (got.valid !== exp.valid || got.first !== exp.first || got.data !== exp.data
			|| (exp.first && got.addr !== exp.addr))
		begin
			error_count++;
			$display("FAILED at %0t: %s first/addr/data got %0b %h %h, expected %0b %h %h",
				$time, what, got.first, got.addr, got.data, exp.first, exp.addr, exp.data);
		end
	endtask

	task automatic compare_luma(input luma_out_t got, input luma_out_t exp, input string what);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("FAILED at %0t: %s first/luma/line got %0b %h %0d, expected %0b %h %0d",
				$time, what, got.first, got.luma, got.line_num, exp.first, exp.luma, exp.line_num);
		end
	endtask

	task automatic wait_for_beats(input int count);
		while (beat_q.size() < count)
			@(posedge clk_100_bus);
	endtask

	task automatic expect_beats(input int line);
		wait_for_beats(PIXELS);
		for (int i = 0; i < PIXELS; i++)
			compare_beat(beat_q.pop_front(), expected_beat(line, i),
				$sformatf("line %0d beat %0d", line, i));
	endtask

	task automatic expect_lumas(input int line);
		while (luma_q.size() < PIXELS)
			@(posedge clk_100_bus);
		for (int i = 0; i < PIXELS; i++)
			compare_luma(luma_q.pop_front(), expected_luma(line, i),
				$sformatf("line %0d luma %0d", line, i));
	endtask

	// Let every outstanding credit get back to the writer
	task automatic drain_credits();
		while (credit_due.size() != 0)
			@(posedge clk_100_bus);
		repeat (3) @(posedge clk_100_bus);
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (error_count == errs_before)
		begin
			tests_passed++;
			$display("%s: pass", name);
		end
		else
		begin
			tests_failed++;
			$display("%s: fail, %0d errors", name, error_count - errs_before);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset_init();
		int errs_before;
		errs_before = error_count;
		check_count++;
		if (beat.valid !== 1'b0 || luma.valid !== 1'b0)
		begin
			error_count++;
			$display("Outputs were active right after reset");
		end
		send_line(1);
		repeat (50) @(posedge clk_100_bus);
		check_count++;
		if (beat_q.size() != 0)
		begin
			error_count++;
			$display("A memory beat came out before memory init was done");
		end
		mem_ready <= 1'b1;
		expect_beats(1);
		luma_q.delete();
		drain_credits();
		report_test("reset_init", errs_before);
	endtask

	task automatic test_single_line();
		int errs_before;
		errs_before = error_count;
		send_line(3);
		expect_beats(3);
		luma_q.delete();
		drain_credits();
		report_test("single_line", errs_before);
	endtask

	task automatic test_luma();
		int errs_before;
		errs_before = error_count;
		send_line(5);
		expect_lumas(5);
		beat_q.delete();
		drain_credits();
		report_test("luma_channel", errs_before);
	endtask

	task automatic test_back_pressure();
		int errs_before;
		errs_before = error_count;
		hold_credits <= 1'b1;
		send_line(9);
		wait_for_beats(CREDITS * BURST);
		repeat (40) @(posedge clk_100_bus);
		check_count++;
		if (beat_q.size() != CREDITS * BURST)
		begin
			error_count++;
			$display("FAILED at %0t: %0d beats with credits withheld, expected %0d",
				$time, beat_q.size(), CREDITS * BURST);
		end
		hold_credits <= 1'b0;
		expect_beats(9);
		luma_q.delete();
		drain_credits();
		report_test("back_pressure", errs_before);
	endtask

	task automatic test_ping_pong();
		int errs_before;
		errs_before = error_count;
		// Credits held so line 6 is still moving while line 7 lands
		hold_credits <= 1'b1;
		send_line(6);
		send_line(7);
		check_count++;
		if (beat_q.size() >= PIXELS)
		begin
			error_count++;
			$display("Line 6 transfer ended before line 7 was captured, banks did not overlap");
		end
		hold_credits <= 1'b0;
		expect_beats(6);
		expect_lumas(6);
		expect_beats(7);
		expect_lumas(7);
		drain_credits();
		report_test("ping_pong", errs_before);
	endtask

	initial
	begin
		rst          = 1'b1;
		pix          = '0;
		mem_ready    = 1'b0;
		hold_credits = 1'b0;
		seed         = 32'h4f99_f346;
		error_count  = 0;
		check_count  = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (2) @(posedge clk_100_bus);
		rst <= 1'b0;
		@(posedge clk_100_bus);
		test_reset_init();
		test_single_line();
		test_luma();
		test_back_pressure();
		test_ping_pong();
		$display("Summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
			tests_passed, tests_failed, check_count, error_count);
		if (error_count == 0 && tests_failed == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== tests/video_to_ram_sva.sv ====
// Burst writer credit and framing assertions
`timescale 1ns/1ps

module video_to_ram_sva #(
	parameter int unsigned BURST_LEN   = video_ram_pkg::DEF_BURST_LEN,
	parameter int unsigned MAX_CREDITS = video_ram_pkg::DEF_MAX_CREDITS,
	parameter int unsigned CREDIT_W    = 2
) (
	input logic                      i_clk_100_bus,
	input logic                      i_rst,
	input logic [CREDIT_W-1:0]       i_credit,
	input logic                      i_credit_take,
	input video_ram_pkg::mem_beat_t  i_beat
);
	import video_ram_pkg::*;

	localparam int unsigned RUN_W = $clog2(BURST_LEN + 1);

	// Valid beats seen so far in the current run
	logic [RUN_W-1:0] run_q;

	always_ff @(posedge i_clk_100_bus or posedge i_rst)
	begin
		if (i_rst)
			run_q <= '0;
		else if (i_beat.valid)
			run_q <= run_q + 1'b1;
		else
			run_q <= '0;
	end

	// Credit counter bounds
	a_credit_max: assert property (@(posedge i_clk_100_bus) disable iff (i_rst)
		i_credit <= CREDIT_W'(MAX_CREDITS)) else $error("credit count above maximum");
	// An empty counter may only stay empty or gain one, never wrap
	a_credit_empty: assert property (@(posedge i_clk_100_bus) disable iff (i_rst)
		(i_credit == '0) |=> (i_credit <= CREDIT_W'(1)))
		else $error("credit count went below zero");

	// Runs of exactly BURST_LEN beats, first flag on the opening beat
	a_run_long: assert property (@(posedge i_clk_100_bus) disable iff (i_rst)
		i_beat.valid |-> (run_q < RUN_W'(BURST_LEN))) else $error("beat run too long");
	a_run_short: assert property (@(posedge i_clk_100_bus) disable iff (i_rst)
		(!i_beat.valid && run_q != '0) |-> (run_q == RUN_W'(BURST_LEN)))
		else $error("beat run too short");
	a_first: assert property (@(posedge i_clk_100_bus) disable iff (i_rst)
		i_beat.valid |-> (i_beat.first == (run_q == '0))) else $error("first flag misplaced");

	// Burst opens two cycles after its credit was taken
	a_paid: assert property (@(posedge i_clk_100_bus) disable iff (i_rst)
		(i_beat.valid && i_beat.first) |-> $past(i_credit_take, 2))
		else $error("burst started without a credit");

endmodule

bind burst_writer video_to_ram_sva #(
	.BURST_LEN   (BURST_LEN),
	.MAX_CREDITS (MAX_CREDITS),
	.CREDIT_W    (CREDIT_W)
) u_sva (
	.i_clk_100_bus (i_clk_100_bus),
	.i_rst         (i_rst),
	.i_credit      (credit_q),
	.i_credit_take (credit_take),
	.i_beat        (o_beat)
);
